// ==== list.f ====
source/priv_pkg.sv
source/priv_irq_if.sv
source/irq_sampler.sv
source/irq_controller.sv
source/csr_file.sv
source/priv_unit.sv
bench/priv_unit_assertions.sv
bench/priv_unit_tb.sv

// ==== Bender.yml ====
package:
  name: priv_unit

sources:
  - source/priv_pkg.sv
  - source/priv_irq_if.sv
  - source/irq_sampler.sv
  - source/irq_controller.sv
  - source/csr_file.sv
  - source/priv_unit.sv
  - target: test
    files:
      - bench/priv_unit_assertions.sv
      - bench/priv_unit_tb.sv

// ==== bench/priv_unit_tb.sv ====
`timescale 1ns/1ps

module priv_unit_tb import priv_pkg::*; ();

	localparam xlen_t BOOT = 32'h0000_8000;
	localparam xlen_t ONES = 32'hFFFF_FFFF;
	localparam xlen_t SATP_RD = ONES & ~SATP_MASK;
	// edges allowed for a rise or release, and the quiet window
	localparam int IRQ_TIMEOUT = 20;
	localparam int IRQ_WINDOW = 12;

	typedef enum logic [2:0] {
		OP_WRITE, OP_READ, OP_ENTER, OP_LEAVE, OP_IRQ, OP_MODE, OP_PAGE, OP_OUT
	} op_t;

	// enter: addr[4] isint, addr[3:0] code, data pc
	// leave: addr[0] mret; irq: data {eip, tip}, exp {reply, rise}
	// out: addr 0 mtvec_out, 1 mepc_out, 2 sepc_out
	typedef struct packed {
		op_t       op;
		csr_addr_t addr;
		xlen_t     data;
		xlen_t     exp;
	} row_t;

	logic clk, rst, we, m_tip, m_eip, m_eip_reply, interrupt, int_reply;
	logic on_exc_enter, on_exc_isint, on_exc_leave, on_exc_ismret, paging;
	csr_addr_t a;
	xlen_t d, spo, pc_in, mtvec_out, mepc_out, sepc_out;
	cause_code_t mcause_code_in;
	priv_mode_t mode;
	logic [21:0] ppn;

	row_t rows[$];
	int checks = 0;
	int errors = 0;
	bit timed_out = 1'b0;

	priv_unit #(.BOOT_VECTOR(BOOT)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic add_row(input op_t op, input csr_addr_t addr, input xlen_t data,
			input xlen_t exp);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.exp = exp;
		rows.push_back(r);
	endtask

	task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	// levels go in, interrupt expected three edges later
	task automatic run_irq(input row_t r);
		int k;
		bit seen;
		seen = 1'b0;
		m_eip = r.data[1];
		m_tip = r.data[0];
		if (!r.exp[0]) begin
			for (k = 1; k <= IRQ_WINDOW; k++) begin
				@(posedge clk);
				#1;
				if (interrupt)
					seen = 1'b1;
			end
			check_value("interrupt while disabled", seen, 0);
			#1;
			m_eip = 1'b0;
			m_tip = 1'b0;
		end else begin
			k = 0;
			while (!interrupt && k < IRQ_TIMEOUT) begin
				@(posedge clk);
				#1;
				k++;
			end
			if (!interrupt) begin
				errors++;
				timed_out = 1'b1;
				$display("timeout at %0t ns: interrupt did not rise within %0d cycles",
					$time, IRQ_TIMEOUT);
			end else begin
				check_value("edges to interrupt", k, 3);
				check_value("m_eip_reply at rise", m_eip_reply, r.exp[1]);
				#1;
				// drop levels early so the controller does not issue again
				m_eip = 1'b0;
				m_tip = 1'b0;
				int_reply = 1'b1;
				k = 0;
				while (interrupt && k < IRQ_TIMEOUT) begin
					@(posedge clk);
					#1;
					k++;
					if (k == 1)
						check_value("m_eip_reply after pulse", m_eip_reply, 0);
				end
				if (interrupt) begin
					errors++;
					timed_out = 1'b1;
					$display("timeout at %0t ns: interrupt still high after int_reply", $time);
				end else begin
					// reply registered, then one more edge
					check_value("edges to release", k, 2);
				end
				#1;
				int_reply = 1'b0;
			end
		end
	endtask

	initial begin
		int i;
		int assert_fails;
		row_t r;
		xlen_t got;

		// reset values
		add_row(OP_READ, CSR_MISA, 0, MISA_INIT);
		add_row(OP_READ, CSR_MSTATUS, 0, MSTATUS_INIT & ~MSTATUS_MASK);
		add_row(OP_READ, CSR_MTVEC, 0, BOOT & ~TVEC_MASK);
		add_row(OP_MODE, 0, 0, MODE_M);
		// all ones in, masked bits read back as zero
		add_row(OP_WRITE, CSR_MTVEC, ONES, 0);
		add_row(OP_READ, CSR_MTVEC, 0, ~TVEC_MASK);
		add_row(OP_WRITE, CSR_MEPC, ONES, 0);
		add_row(OP_READ, CSR_MEPC, 0, ~EPC_MASK);
		add_row(OP_WRITE, CSR_MIE, ONES, 0);
		add_row(OP_READ, CSR_MIE, 0, ~MIE_MASK);
		add_row(OP_WRITE, CSR_SATP, ONES, 0);
		add_row(OP_READ, CSR_SATP, 0, SATP_RD);
		add_row(OP_PAGE, 0, 0, {SATP_RD[31], SATP_RD[21:0]});
		add_row(OP_WRITE, CSR_SSTATUS, ONES, 0);
		add_row(OP_READ, CSR_SSTATUS, 0, ~SSTATUS_MASK);
		add_row(OP_WRITE, CSR_MEDELEG, ONES, 0);
		add_row(OP_READ, CSR_MEDELEG, 0, 0);
		add_row(OP_WRITE, 12'h7C0, ONES, 0);
		add_row(OP_READ, 12'h7C0, 0, 0);
		add_row(OP_WRITE, CSR_MTVEC, 32'h0000_4000, 0);
		add_row(OP_READ, CSR_MTVEC, 0, 32'h0000_4000);
		add_row(OP_OUT, 0, 0, 32'h0000_4000);
		// sepc copy, low bits stay at their reset zero
		add_row(OP_WRITE, CSR_SEPC, 32'h0000_5003, 0);
		add_row(OP_READ, CSR_SEPC, 0, 32'h0000_5000);
		add_row(OP_OUT, 2, 0, 32'h0000_5000);
		// exception taken from M mode with MIE set
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0008, 0);
		add_row(OP_ENTER, 12'h002, 32'h0000_1234, 0);
		add_row(OP_OUT, 1, 0, ONES & ~EPC_MASK);
		add_row(OP_OUT, 1, 0, 32'h0000_1234);
		add_row(OP_READ, CSR_MCAUSE, 0, 2);
		add_row(OP_READ, CSR_MSTATUS, 0, 32'h0000_1880);
		add_row(OP_MODE, 0, 0, MODE_M);
		// mret into S mode
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0880, 0);
		add_row(OP_LEAVE, 12'h001, 0, 0);
		add_row(OP_MODE, 0, 0, MODE_S);
		add_row(OP_READ, CSR_MSTATUS, 0, 32'h0000_0088);
		// exception from S, unaligned pc
		add_row(OP_ENTER, 12'h005, 32'h0000_2002, 0);
		add_row(OP_READ, CSR_MEPC, 0, 32'h0000_2000);
		add_row(OP_READ, CSR_MSTATUS, 0, 32'h0000_0880);
		// sret with SPP set
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0120, 0);
		add_row(OP_LEAVE, 12'h000, 0, 0);
		add_row(OP_MODE, 0, 0, MODE_S);
		add_row(OP_READ, CSR_MSTATUS, 0, 32'h0000_0022);
		// external interrupt
		add_row(OP_WRITE, CSR_MIE, 32'h0000_0800, 0);
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0008, 0);
		add_row(OP_IRQ, 0, 32'h2, 32'h3);
		add_row(OP_ENTER, 12'h010, 32'h0000_3000, 0);
		add_row(OP_READ, CSR_MCAUSE, 0, 32'h8000_0000 | CAUSE_M_EXT);
		// timer only
		add_row(OP_WRITE, CSR_MIE, 32'h0000_0080, 0);
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0008, 0);
		add_row(OP_IRQ, 0, 32'h1, 32'h1);
		add_row(OP_ENTER, 12'h010, 32'h0000_3100, 0);
		add_row(OP_READ, CSR_MCAUSE, 0, 32'h8000_0000 | CAUSE_M_TIMER);
		// external not enabled, then global enable off
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0008, 0);
		add_row(OP_IRQ, 0, 32'h2, 32'h0);
		add_row(OP_WRITE, CSR_MSTATUS, 32'h0000_0000, 0);
		add_row(OP_WRITE, CSR_MIE, 32'h0000_0880, 0);
		add_row(OP_IRQ, 0, 32'h3, 32'h0);

		rst = 1'b1;
		a = '0;
		d = '0;
		we = 1'b0;
		m_tip = 1'b0;
		m_eip = 1'b0;
		int_reply = 1'b0;
		on_exc_enter = 1'b0;
		on_exc_isint = 1'b0;
		on_exc_leave = 1'b0;
		on_exc_ismret = 1'b0;
		pc_in = '0;
		mcause_code_in = '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		for (i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			#2;
			// strobes last one cycle
			we = 1'b0;
			on_exc_enter = 1'b0;
			on_exc_leave = 1'b0;
			r = rows[i];
			case (r.op)
				OP_WRITE: begin
					a = r.addr;
					d = r.data;
					we = 1'b1;
				end
				OP_READ: begin
					a = r.addr;
					#5;
					check_value($sformatf("read of csr %h", r.addr), spo, r.exp);
				end
				OP_ENTER: begin
					on_exc_enter = 1'b1;
					on_exc_isint = r.addr[4];
					mcause_code_in = r.addr[3:0];
					pc_in = r.data;
				end
				OP_LEAVE: begin
					on_exc_leave = 1'b1;
					on_exc_ismret = r.addr[0];
				end
				OP_MODE: check_value("mode", mode, r.exp);
				OP_PAGE: check_value("paging and ppn", {paging, ppn}, r.exp);
				OP_OUT: begin
					case (r.addr[1:0])
						2'd0: got = mtvec_out;
						2'd1: got = mepc_out;
						default: got = sepc_out;
					endcase
					check_value($sformatf("trap output %0d", r.addr[1:0]), got, r.exp);
				end
				default: run_irq(r);
			endcase
			if (timed_out)
				break;
		end

		// failures of the bound checker count as well
		assert_fails = uut.u_controller.u_assertions.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== bench/priv_unit_assertions.sv ====
`timescale 1ns/1ps

module priv_unit_assertions (
	input logic clk,
	input logic rst,
	input logic interrupt,
	input logic m_eip_reply,
	input logic int_reply_q
);

	// number of failed assertions
	int fail_count = 0;

	// external reply is a single pulse
	property reply_single_pulse;
		@(posedge clk) disable iff (rst) m_eip_reply |=> !m_eip_reply;
	endproperty

	// interrupt is only released by the registered reply
	property interrupt_held;
		@(posedge clk) disable iff (rst) (interrupt && !int_reply_q) |=> interrupt;
	endproperty

	// quiet right after reset
	property interrupt_low_after_reset;
		@(posedge clk) rst |=> !interrupt;
	endproperty

	assert property (reply_single_pulse)
		else begin
			fail_count++;
			$error("m_eip_reply high for two cycles in a row");
		end
	assert property (interrupt_held)
		else begin
			fail_count++;
			$error("interrupt dropped without a registered reply");
		end
	assert property (interrupt_low_after_reset)
		else begin
			fail_count++;
			$error("interrupt high in the cycle after reset");
		end

endmodule

bind irq_controller priv_unit_assertions u_assertions (
	.clk         (clk),
	.rst         (rst),
	.interrupt   (interrupt),
	.m_eip_reply (m_eip_reply),
	.int_reply_q (int_reply_q)
);

// ==== source/priv_unit.sv ====
`timescale 1ns/1ps

module priv_unit import priv_pkg::*; #(
	parameter xlen_t BOOT_VECTOR = '0
) (
	input  logic        clk,
	input  logic        rst,
	// CSR access from the CPU
	input  csr_addr_t   a,
	input  xlen_t       d,
	input  logic        we,
	output xlen_t       spo,
	// timer and external interrupt levels
	input  logic        m_tip,
	input  logic        m_eip,
	output logic        m_eip_reply,
	// trap entry and return
	input  logic        on_exc_enter,
	input  logic        on_exc_isint,
	input  xlen_t       pc_in,
	input  cause_code_t mcause_code_in,
	input  logic        on_exc_leave,
	input  logic        on_exc_ismret,
	output xlen_t       mtvec_out,
	output xlen_t       mepc_out,
	output xlen_t       sepc_out,
	// interrupt toward the CPU
	output logic        interrupt,
	input  logic        int_reply,
	// status for the MMU and pipeline
	output priv_mode_t  mode,
	output logic        paging,
	output logic [21:0] ppn
);

	priv_irq_if irq_bus ();

	// stage one samples levels and enables
	irq_sampler u_sampler (
		.clk   (clk),
		.rst   (rst),
		.m_tip (m_tip),
		.m_eip (m_eip),
		.irq   (irq_bus.sampler)
	);

	// stage two drives the CPU interrupt
	irq_controller u_controller (
		.clk         (clk),
		.rst         (rst),
		.int_reply   (int_reply),
		.interrupt   (interrupt),
		.m_eip_reply (m_eip_reply),
		.irq         (irq_bus.ctrl)
	);

	csr_file #(
		.BOOT_VECTOR (BOOT_VECTOR)
	) u_csr (
		.clk            (clk),
		.rst            (rst),
		.a              (a),
		.d              (d),
		.we             (we),
		.spo            (spo),
		.m_tip          (m_tip),
		.m_eip          (m_eip),
		.on_exc_enter   (on_exc_enter),
		.on_exc_isint   (on_exc_isint),
		.pc_in          (pc_in),
		.mcause_code_in (mcause_code_in),
		.on_exc_leave   (on_exc_leave),
		.on_exc_ismret  (on_exc_ismret),
		.mtvec_out      (mtvec_out),
		.mepc_out       (mepc_out),
		.sepc_out       (sepc_out),
		.mode           (mode),
		.paging         (paging),
		.ppn            (ppn),
		.irq            (irq_bus.csr)
	);

endmodule

// ==== source/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import priv_pkg::*; #(
	parameter xlen_t BOOT_VECTOR = '0
) (
	input  logic        clk,
	input  logic        rst,
	input  csr_addr_t   a,
	input  xlen_t       d,
	input  logic        we,
	output xlen_t       spo,
	input  logic        m_tip,
	input  logic        m_eip,
	input  logic        on_exc_enter,
	input  logic        on_exc_isint,
	input  xlen_t       pc_in,
	input  cause_code_t mcause_code_in,
	input  logic        on_exc_leave,
	input  logic        on_exc_ismret,
	output xlen_t       mtvec_out,
	output xlen_t       mepc_out,
	output xlen_t       sepc_out,
	output priv_mode_t  mode,
	output logic        paging,
	output logic [21:0] ppn,
	priv_irq_if.csr     irq
);

	// mstatus fields
	localparam int SIE_BIT  = 1;
	localparam int MIE_BIT  = 3;
	localparam int SPIE_BIT = 5;
	localparam int MPIE_BIT = 7;
	localparam int SPP_BIT  = 8;
	localparam int MPP_LO   = 11;
	// same positions in mie and mip
	localparam int TMR_BIT = 7;
	localparam int EXT_BIT = 11;

	xlen_t mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval;
	xlen_t stvec, sscratch, sepc, scause, stval, satp;

	// live pending levels seen through mip
	xlen_t mip_live;
	// mstatus after trap entry, mret and sret
	xlen_t mstatus_trap, mstatus_mret, mstatus_sret;
	cause_code_t trap_code;

	// keep masked bits, take the rest from the write data
	function automatic xlen_t wr_masked(input xlen_t cur, input xlen_t val, input xlen_t mask);
		return (cur & mask) | (val & ~mask);
	endfunction

	always_comb begin
		mip_live = '0;
		mip_live[EXT_BIT] = m_eip;
		mip_live[TMR_BIT] = m_tip;
	end

	// combinational read port
	always_comb begin
		case (a)
			CSR_SSTATUS:  spo = mstatus & ~SSTATUS_MASK;
			CSR_SIE:      spo = mie & ~SIE_MASK;
			CSR_STVEC:    spo = stvec & ~TVEC_MASK;
			CSR_SSCRATCH: spo = sscratch;
			CSR_SEPC:     spo = sepc & ~EPC_MASK;
			CSR_SCAUSE:   spo = scause;
			CSR_STVAL:    spo = stval;
			// no delegation so nothing is pending for S mode
			CSR_SIP:      spo = '0;
			CSR_SATP:     spo = satp & ~SATP_MASK;
			CSR_MSTATUS:  spo = mstatus & ~MSTATUS_MASK;
			CSR_MISA:     spo = misa;
			CSR_MEDELEG:  spo = '0;
			CSR_MIDELEG:  spo = '0;
			CSR_MIE:      spo = mie & ~MIE_MASK;
			CSR_MTVEC:    spo = mtvec & ~TVEC_MASK;
			CSR_MSCRATCH: spo = mscratch;
			CSR_MEPC:     spo = mepc & ~EPC_MASK;
			CSR_MCAUSE:   spo = mcause;
			CSR_MTVAL:    spo = mtval;
			// only the M level pins are wired
			CSR_MIP:      spo = mip_live & MIP_MASK;
			default:      spo = '0;
		endcase
	end

	// next mstatus for the trap cases
	always_comb begin
		mstatus_trap = mstatus;
		mstatus_trap[MPP_LO +: 2] = mode;
		mstatus_trap[MPIE_BIT] = mstatus[MIE_BIT];
		mstatus_trap[MIE_BIT] = 1'b0;

		mstatus_mret = mstatus;
		mstatus_mret[MPP_LO +: 2] = MODE_U;
		mstatus_mret[MIE_BIT] = mstatus[MPIE_BIT];
		mstatus_mret[MPIE_BIT] = 1'b1;

		mstatus_sret = mstatus;
		mstatus_sret[SPP_BIT] = 1'b0;
		mstatus_sret[SIE_BIT] = mstatus[SPIE_BIT];
		mstatus_sret[SPIE_BIT] = 1'b1;
	end

	// interrupt cause comes from the controller
	assign trap_code = on_exc_isint ? irq.cause_code : mcause_code_in;

	// CSR write beats trap entry, trap entry beats return
	always_ff @(posedge clk) begin
		if (rst) begin
			mode     <= MODE_M;
			mstatus  <= MSTATUS_INIT;
			misa     <= MISA_INIT;
			mie      <= '0;
			mtvec    <= BOOT_VECTOR;
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtval    <= '0;
			stvec    <= '0;
			sscratch <= '0;
			sepc     <= '0;
			scause   <= '0;
			stval    <= '0;
			satp     <= '0;
		end else if (we) begin
			case (a)
				CSR_SSTATUS:  mstatus  <= wr_masked(mstatus, d, SSTATUS_MASK);
				CSR_SIE:      mie      <= wr_masked(mie, d, SIE_MASK);
				CSR_STVEC:    stvec    <= wr_masked(stvec, d, TVEC_MASK);
				CSR_SSCRATCH: sscratch <= d;
				CSR_SEPC:     sepc     <= wr_masked(sepc, d, EPC_MASK);
				CSR_SCAUSE:   scause   <= d;
				CSR_STVAL:    stval    <= d;
				CSR_SATP:     satp     <= wr_masked(satp, d, SATP_MASK);
				CSR_MSTATUS:  mstatus  <= wr_masked(mstatus, d, MSTATUS_MASK);
				CSR_MIE:      mie      <= wr_masked(mie, d, MIE_MASK);
				CSR_MTVEC:    mtvec    <= wr_masked(mtvec, d, TVEC_MASK);
				CSR_MSCRATCH: mscratch <= d;
				CSR_MEPC:     mepc     <= wr_masked(mepc, d, EPC_MASK);
				CSR_MCAUSE:   mcause   <= d;
				CSR_MTVAL:    mtval    <= d;
				// misa and unknown addresses ignore writes
				default: ;
			endcase
		end else if (on_exc_enter) begin
			// every trap is taken in M mode
			mode    <= MODE_M;
			mstatus <= mstatus_trap;
			mepc    <= pc_in;
			mcause  <= {on_exc_isint, 27'b0, trap_code};
		end else if (on_exc_leave) begin
			if (on_exc_ismret) begin
				mode    <= mstatus[MPP_LO +: 2];
				mstatus <= mstatus_mret;
			end else begin
				// SPP only tells S from U
				mode    <= mstatus[SPP_BIT] ? MODE_S : MODE_U;
				mstatus <= mstatus_sret;
			end
		end
	end

	// copies for the CPU, one cycle behind
	always_ff @(posedge clk) begin
		mtvec_out <= mtvec;
		mepc_out  <= mepc;
		sepc_out  <= sepc;
	end

	// enables toward the interrupt sampler
	assign irq.global_ie = mstatus[MIE_BIT];
	assign irq.meie      = mie[EXT_BIT];
	assign irq.mtie      = mie[TMR_BIT];

	// Sv32 mode bit and root page number
	assign paging = satp[31];
	assign ppn    = satp[21:0];

endmodule

// ==== source/irq_controller.sv ====
`timescale 1ns/1ps

module irq_controller import priv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic int_reply,
	output logic interrupt,
	output logic m_eip_reply,
	priv_irq_if.ctrl irq
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_REPLY,
		ST_DONE
	} irq_state_t;

	irq_state_t state;

	// source captured on leaving idle
	logic [1:0] src_q;
	// CPU reply, one cycle late
	logic int_reply_q;
	cause_code_t cause_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			int_reply_q <= 1'b0;
		end else begin
			int_reply_q <= int_reply;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_IDLE;
			src_q       <= 2'b00;
			cause_q     <= '0;
			interrupt   <= 1'b0;
			m_eip_reply <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (irq.pending) begin
						src_q <= irq.source;
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					interrupt <= 1'b1;
					// external wins over timer
					if (src_q[1]) begin
						cause_q     <= CAUSE_M_EXT;
						// external controller gets a single pulse
						m_eip_reply <= 1'b1;
					end else if (src_q[0]) begin
						cause_q <= CAUSE_M_TIMER;
					end else begin
						cause_q <= CAUSE_M_SOFT;
					end
					state <= ST_REPLY;
				end
				ST_REPLY: begin
					m_eip_reply <= 1'b0;
					// hold interrupt until the CPU answers
					if (int_reply_q) begin
						interrupt <= 1'b0;
						state     <= ST_DONE;
					end
				end
				ST_DONE: begin
					// one idle gap before the next request
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// cause stays valid after interrupt drops for trap entry
	assign irq.cause_code = cause_q;

endmodule

// ==== source/irq_sampler.sv ====
`timescale 1ns/1ps

module irq_sampler (
	input  logic clk,
	input  logic rst,
	input  logic m_tip,
	input  logic m_eip,
	priv_irq_if.sampler irq
);

	// registered levels and enables
	logic tip_q;
	logic eip_q;
	logic mtie_q;
	logic meie_q;
	logic gie_q;

	// enabled sources from the registered copies
	logic ext_req;
	logic tmr_req;

	// levels and enables captured in the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			tip_q  <= 1'b0;
			eip_q  <= 1'b0;
			mtie_q <= 1'b0;
			meie_q <= 1'b0;
			gie_q  <= 1'b0;
		end else begin
			tip_q  <= m_tip;
			eip_q  <= m_eip;
			mtie_q <= irq.mtie;
			meie_q <= irq.meie;
			gie_q  <= irq.global_ie;
		end
	end

	assign ext_req = eip_q & meie_q;
	assign tmr_req = tip_q & mtie_q;

	// no software interrupt source
	assign irq.source  = {ext_req, tmr_req};
	assign irq.pending = gie_q & (ext_req | tmr_req);

endmodule

// ==== source/priv_irq_if.sv ====
`timescale 1ns/1ps

interface priv_irq_if import priv_pkg::*; ();

	// enables from the CSR file
	logic global_ie;
	logic meie;
	logic mtie;

	// sampled request, bit 1 external and bit 0 timer
	logic       pending;
	logic [1:0] source;

	// interrupt cause for trap entry
	cause_code_t cause_code;

	modport csr (
		output global_ie, meie, mtie,
		input  cause_code
	);

	modport sampler (
		input  global_ie, meie, mtie,
		output pending, source
	);

	modport ctrl (
		input  pending, source,
		output cause_code
	);

endinterface

// ==== source/priv_pkg.sv ====
package priv_pkg;

	// data word and CSR address
	typedef logic [31:0] xlen_t;
	typedef logic [11:0] csr_addr_t;

	// privilege level as in mstatus.MPP
	typedef logic [1:0] priv_mode_t;

	// low bits of mcause
	typedef logic [3:0] cause_code_t;

	// privilege modes, hypervisor level not implemented
	localparam priv_mode_t MODE_M = 2'd3;
	localparam priv_mode_t MODE_S = 2'd1;
	localparam priv_mode_t MODE_U = 2'd0;

	// supervisor CSRs
	localparam csr_addr_t CSR_SSTATUS  = 12'h100;
	localparam csr_addr_t CSR_SIE      = 12'h104;
	localparam csr_addr_t CSR_STVEC    = 12'h105;
	localparam csr_addr_t CSR_SSCRATCH = 12'h140;
	localparam csr_addr_t CSR_SEPC     = 12'h141;
	localparam csr_addr_t CSR_SCAUSE   = 12'h142;
	localparam csr_addr_t CSR_STVAL    = 12'h143;
	localparam csr_addr_t CSR_SIP      = 12'h144;
	localparam csr_addr_t CSR_SATP     = 12'h180;

	// machine CSRs
	localparam csr_addr_t CSR_MSTATUS  = 12'h300;
	localparam csr_addr_t CSR_MISA     = 12'h301;
	localparam csr_addr_t CSR_MEDELEG  = 12'h302;
	localparam csr_addr_t CSR_MIDELEG  = 12'h303;
	localparam csr_addr_t CSR_MIE      = 12'h304;
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;
	localparam csr_addr_t CSR_MTVAL    = 12'h343;
	localparam csr_addr_t CSR_MIP      = 12'h344;

	// RV32 with A, I, M, S and U extensions
	localparam xlen_t MISA_INIT = 32'h4014_1101;

	// SPIE, MPIE, SPP set and MPP at machine mode
	localparam xlen_t MSTATUS_INIT = 32'h0000_19A0;

	// set bit reads zero and keeps its value on a write
	// mstatus live bits are 1, 3, 5, 7, 8, 11 and 12
	localparam xlen_t MSTATUS_MASK = 32'hFFFF_E655;
	// sstatus only exposes SIE, SPIE and SPP
	localparam xlen_t SSTATUS_MASK = 32'hFFFF_FEDD;

	// mie keeps the M and S enables
	localparam xlen_t MIE_MASK = 32'hFFFF_F555;
	// sie keeps the S enables only
	localparam xlen_t SIE_MASK = 32'hFFFF_FDDD;

	// vector mode bits unsupported, direct mode only
	localparam xlen_t TVEC_MASK = 32'h0000_0003;
	// instructions are word aligned
	localparam xlen_t EPC_MASK = 32'h0000_0003;

	// mip pending bits for the supervisor side are never set
	localparam xlen_t MIP_MASK = 32'hFFFF_FDDD;

	// ASID field not implemented
	localparam xlen_t SATP_MASK = 32'h7FC0_0000;

	// interrupt cause codes, mcause bit 31 set separately
	localparam cause_code_t CAUSE_M_EXT   = 4'd11;
	localparam cause_code_t CAUSE_M_TIMER = 4'd7;
	localparam cause_code_t CAUSE_M_SOFT  = 4'd3;

endpackage
